/* Bender.yml */
package:
  name: mem_stage

sources:
  - mem_pkg.sv
  - rep_stepper.sv
  - dmem.sv
  - opswap.sv
  - mem_out_reg.sv
  - mem_stage.sv
  - target: test
    files:
      - tb_mem_stage.sv

/* dmem.sv */
`timescale 1ns/1ps

module dmem #(
    parameter int dmem_words = 64
) (
    input  logic                       clk,
    input  mem_pkg::wb_write_t         wb,
    input  logic [mem_pkg::addr_w-1:0] raddr1,
    input  logic [mem_pkg::addr_w-1:0] raddr2,
    output logic [mem_pkg::data_w-1:0] rdata1,
    output logic [mem_pkg::data_w-1:0] rdata2
);

    localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    // stands in for the data cache, one 64-bit word per entry
    logic [mem_pkg::data_w-1:0] mem [dmem_words];

    // byte address to word slot, wrapping at the array size
    function automatic logic [idx_w-1:0] word_idx(input logic [mem_pkg::addr_w-1:0] a);
        return idx_w'((a >> 3) % dmem_words);
    endfunction

    // asynchronous reads see the value before a same-cycle write
    assign rdata1 = mem[word_idx(raddr1)];
    assign rdata2 = mem[word_idx(raddr2)];

    // writeback port
    always_ff @(posedge clk) begin
        if (wb.valid) begin
            mem[word_idx(wb.addr)] <= wb.data;
        end
    end

    a_wb_addr_known : assert property (
        @(posedge clk)
        wb.valid |-> !$isunknown(wb.addr)
    );

endmodule

/* flist.f */
mem_pkg.sv
rep_stepper.sv
dmem.sv
opswap.sv
mem_out_reg.sv
mem_stage.sv
tb_mem_stage.sv

/* mem_out_reg.sv */
`timescale 1ns/1ps

module mem_out_reg (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clr,
    input  logic                 fwd_stall,
    input  mem_pkg::mem_result_t d,
    output mem_pkg::mem_result_t q
);

    // flush wins over hold, hold wins over load
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (clr) begin
            q <= '0;
        end else if (!fwd_stall) begin
            q <= d;
        end
    end

    // downstream sees the same item for as long as it stalls
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!arst_n)
        (fwd_stall && !clr) |=> $stable(q)
    );

endmodule

/* mem_pkg.sv */
package mem_pkg;

    // datapath widths
    parameter int addr_w  = 32;
    parameter int data_w  = 64;
    parameter int tag_w   = 16;
    parameter int num_ops = 4;

    // operand source codes
    // reg and seg codes keep the slot index in the low two bits
    typedef enum logic [3:0] {
        src_reg0 = 4'd0,
        src_reg1 = 4'd1,
        src_reg2 = 4'd2,
        src_reg3 = 4'd3,
        src_seg0 = 4'd4,
        src_seg1 = 4'd5,
        src_seg2 = 4'd6,
        src_seg3 = 4'd7,
        src_mem1 = 4'd8,
        src_mem2 = 4'd9,
        src_eip  = 4'd10,
        src_imm  = 4'd11,
        src_zero = 4'd12
    } src_e;

    typedef enum logic [1:0] {
        dest_none = 2'd0,
        dest_reg  = 2'd1,
        dest_seg  = 2'd2,
        dest_mem  = 2'd3
    } dest_kind_e;

    typedef struct packed {
        dest_kind_e kind;
        logic [1:0] idx;
    } dest_sel_t;

    // decoded micro-op from the decode stage
    typedef struct packed {
        logic                        valid;
        logic [1:0]                  opsize;
        logic                        is_rep;
        logic                        df;
        logic [addr_w-1:0]           mem_addr1;
        logic [addr_w-1:0]           mem_addr2;
        logic [31:0]                 rep_count;
        logic [31:0]                 eip;
        logic [47:0]                 imm;
        src_e      [num_ops-1:0]     op_sel;
        dest_sel_t [num_ops-1:0]     dest_sel;
        logic [tag_w-1:0]            tag;
    } mem_uop_t;

    typedef struct packed {
        logic [num_ops-1:0][data_w-1:0] gpr;
        logic [num_ops-1:0][15:0]       seg;
    } reg_read_t;

    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } wb_write_t;

    // addr is the reg index, seg index or memory address
    typedef struct packed {
        dest_kind_e        kind;
        logic [addr_w-1:0] addr;
    } dest_t;

    typedef struct packed {
        logic                           valid;
        logic [1:0]                     opsize;
        logic [num_ops-1:0][data_w-1:0] op_val;
        dest_t [num_ops-1:0]            dest;
        logic [31:0]                    eip;
        logic [tag_w-1:0]               tag;
        logic                           last;
    } mem_result_t;

endpackage

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int dmem_words = 64
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 clr,
    input  mem_pkg::mem_uop_t    uop,
    input  mem_pkg::reg_read_t   regs,
    input  mem_pkg::wb_write_t   wb,
    input  logic                 fwd_stall,
    output mem_pkg::mem_result_t result,
    output logic                 stall
);

    // current iteration addresses
    logic [mem_pkg::addr_w-1:0] mem1;
    logic [mem_pkg::addr_w-1:0] mem2;
    logic                       go;
    logic                       last;

    logic [mem_pkg::data_w-1:0] rdata1;
    logic [mem_pkg::data_w-1:0] rdata2;

    // unregistered stage result
    mem_pkg::mem_result_t res_d;

    rep_stepper u_stepper (
        .clk       (clk),
        .arst_n    (arst_n),
        .clr       (clr),
        .uop       (uop),
        .fwd_stall (fwd_stall),
        .mem1      (mem1),
        .mem2      (mem2),
        .go        (go),
        .last      (last),
        .stall     (stall)
    );

    dmem #(
        .dmem_words (dmem_words)
    ) u_dmem (
        .clk    (clk),
        .wb     (wb),
        .raddr1 (mem1),
        .raddr2 (mem2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    opswap u_opswap (
        .uop    (uop),
        .regs   (regs),
        .mem1   (mem1),
        .mem2   (mem2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .go     (go),
        .last   (last),
        .res    (res_d)
    );

    mem_out_reg u_out_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .clr       (clr),
        .fwd_stall (fwd_stall),
        .d         (res_d),
        .q         (result)
    );

endmodule

/* opswap.sv */
`timescale 1ns/1ps

module opswap (
    input  mem_pkg::mem_uop_t          uop,
    input  mem_pkg::reg_read_t         regs,
    input  logic [mem_pkg::addr_w-1:0] mem1,
    input  logic [mem_pkg::addr_w-1:0] mem2,
    input  logic [mem_pkg::data_w-1:0] rdata1,
    input  logic [mem_pkg::data_w-1:0] rdata2,
    input  logic                       go,
    input  logic                       last,
    output mem_pkg::mem_result_t       res
);

    always_comb begin
        res        = '0;
        res.valid  = go;
        res.last   = last;
        res.opsize = uop.opsize;
        res.eip    = uop.eip;
        res.tag    = uop.tag;

        // operand values
        for (int i = 0; i < mem_pkg::num_ops; i++) begin
            case (uop.op_sel[i])
                mem_pkg::src_reg0, mem_pkg::src_reg1,
                mem_pkg::src_reg2, mem_pkg::src_reg3: begin
                    res.op_val[i] = regs.gpr[uop.op_sel[i][1:0]];
                end
                mem_pkg::src_seg0, mem_pkg::src_seg1,
                mem_pkg::src_seg2, mem_pkg::src_seg3: begin
                    // segment selectors are zero-extended
                    res.op_val[i] = mem_pkg::data_w'(regs.seg[uop.op_sel[i][1:0]]);
                end
                mem_pkg::src_mem1: res.op_val[i] = rdata1;
                mem_pkg::src_mem2: res.op_val[i] = rdata2;
                mem_pkg::src_eip:  res.op_val[i] = mem_pkg::data_w'(uop.eip);
                // immediate is sign-extended from 48 bits
                mem_pkg::src_imm:  res.op_val[i] = mem_pkg::data_w'($signed(uop.imm));
                default:           res.op_val[i] = '0;
            endcase
        end

        // destination kind and address
        for (int i = 0; i < mem_pkg::num_ops; i++) begin
            res.dest[i].kind = uop.dest_sel[i].kind;
            case (uop.dest_sel[i].kind)
                mem_pkg::dest_reg, mem_pkg::dest_seg: begin
                    res.dest[i].addr = mem_pkg::addr_w'(uop.dest_sel[i].idx);
                end
                mem_pkg::dest_mem: begin
                    // slot 0 writes to the first stream, the rest to the second
                    res.dest[i].addr = (uop.dest_sel[i].idx == 2'd0) ? mem1 : mem2;
                end
                default: begin
                    res.dest[i].addr = '0;
                end
            endcase
        end
    end

endmodule

/* rep_stepper.sv */
`timescale 1ns/1ps

module rep_stepper (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       clr,
    input  mem_pkg::mem_uop_t          uop,
    input  logic                       fwd_stall,
    output logic [mem_pkg::addr_w-1:0] mem1,
    output logic [mem_pkg::addr_w-1:0] mem2,
    output logic                       go,
    output logic                       last,
    output logic                       stall
);

    // in_rep selects the walker registers over the uop fields
    logic                       in_rep;
    logic [31:0]                cnt_q;
    logic [mem_pkg::addr_w-1:0] off_q;

    logic [31:0]                cur_cnt;
    logic [mem_pkg::addr_w-1:0] cur_off;
    logic [mem_pkg::addr_w-1:0] step;

    // first rep iteration takes its count from the uop
    assign cur_cnt = in_rep ? cnt_q : uop.rep_count;
    assign cur_off = in_rep ? off_q : '0;

    // element size in bytes
    assign step = mem_pkg::addr_w'(1) << uop.opsize;

    // a rep with zero count issues nothing
    assign go   = uop.valid && (!uop.is_rep || (cur_cnt != 32'd0));
    assign last = go && (!uop.is_rep || (cur_cnt == 32'd1));

    // df set walks downward
    always_comb begin
        if (uop.df) begin
            mem1 = uop.mem_addr1 - cur_off;
            mem2 = uop.mem_addr2 - cur_off;
        end else begin
            mem1 = uop.mem_addr1 + cur_off;
            mem2 = uop.mem_addr2 + cur_off;
        end
    end

    // upstream holds the uop until the final iteration leaves
    assign stall = fwd_stall || (go && !last);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_rep <= 1'b0;
            cnt_q  <= '0;
            off_q  <= '0;
        end else if (clr) begin
            in_rep <= 1'b0;
            cnt_q  <= '0;
            off_q  <= '0;
        end else if (!fwd_stall) begin
            if (go && !last) begin
                in_rep <= 1'b1;
                cnt_q  <= cur_cnt - 32'd1;
                off_q  <= cur_off + step;
            end else begin
                // rep done or nothing issued
                in_rep <= 1'b0;
                cnt_q  <= '0;
                off_q  <= '0;
            end
        end
    end

    // the rep uop stays in place while its walk is in progress
    a_rep_uop_held : assert property (
        @(posedge clk) disable iff (!arst_n)
        (in_rep && !clr) |-> (uop.valid && uop.is_rep)
    );

endmodule

/* tb_mem_stage.sv */
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int dmem_words = 64;

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 clr;
    mem_pkg::mem_uop_t    uop;
    mem_pkg::reg_read_t   regs;
    mem_pkg::wb_write_t   wb;
    logic                 fwd_stall;
    mem_pkg::mem_result_t result;
    logic                 stall;

    // model state
    logic [31:0]          lcg_state;
    logic [63:0]          shadow [dmem_words];
    mem_pkg::mem_result_t exp_q [$];
    mem_pkg::mem_result_t exp_cur;
    logic                 exp_full;
    logic                 exp_issue;

    mem_stage #(
        .dmem_words (dmem_words)
    ) dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .clr       (clr),
        .uop       (uop),
        .regs      (regs),
        .wb        (wb),
        .fwd_stall (fwd_stall),
        .result    (result),
        .stall     (stall)
    );

    initial begin
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int word_index(input logic [31:0] a);
        return int'((a >> 3) % dmem_words);
    endfunction

    // expected output for iteration iter out of n
    function automatic mem_pkg::mem_result_t expect_result(input mem_pkg::mem_uop_t u,
                                                           input mem_pkg::reg_read_t r,
                                                           input int iter, input int n);
        mem_pkg::mem_result_t e;
        logic [31:0]          off;
        logic [31:0]          a1;
        logic [31:0]          a2;
        int                   code;
        e = '0;
        off = 32'(iter) << u.opsize;
        a1 = u.df ? u.mem_addr1 - off : u.mem_addr1 + off;
        a2 = u.df ? u.mem_addr2 - off : u.mem_addr2 + off;
        e.valid = 1'b1;
        e.last = (iter == n - 1);
        e.opsize = u.opsize;
        e.eip = u.eip;
        e.tag = u.tag;
        for (int k = 0; k < mem_pkg::num_ops; k++) begin
            code = int'(u.op_sel[k]);
            if (code < 4) e.op_val[k] = r.gpr[code];
            else if (code < 8) e.op_val[k] = {48'd0, r.seg[code - 4]};
            else if (code == 8) e.op_val[k] = shadow[word_index(a1)];
            else if (code == 9) e.op_val[k] = shadow[word_index(a2)];
            else if (code == 10) e.op_val[k] = {32'd0, u.eip};
            else if (code == 11) e.op_val[k] = {{16{u.imm[47]}}, u.imm};
            else e.op_val[k] = '0;
            e.dest[k].kind = u.dest_sel[k].kind;
            case (u.dest_sel[k].kind)
                mem_pkg::dest_reg, mem_pkg::dest_seg: e.dest[k].addr = {30'd0, u.dest_sel[k].idx};
                mem_pkg::dest_mem: e.dest[k].addr = (u.dest_sel[k].idx == 2'd0) ? a1 : a2;
                default: e.dest[k].addr = '0;
            endcase
        end
        return e;
    endfunction

    function automatic mem_pkg::reg_read_t random_regs();
        mem_pkg::reg_read_t r;
        logic [31:0]        t;
        for (int k = 0; k < mem_pkg::num_ops; k++) begin
            r.gpr[k] = {rand32(), rand32()};
            t = rand32();
            r.seg[k] = t[15:0];
        end
        return r;
    endfunction

    function automatic mem_pkg::mem_uop_t random_uop(input logic rep, input int count);
        mem_pkg::mem_uop_t u;
        logic [31:0]       t;
        logic [31:0]       s;
        t = rand32();
        s = rand32();
        u.valid = 1'b1;
        u.opsize = t[1:0];
        u.df = t[2];
        u.is_rep = rep;
        u.mem_addr1 = rand32();
        u.mem_addr2 = rand32();
        u.rep_count = rep ? 32'(count) : rand32();
        u.eip = rand32();
        u.imm = {rand32(), t[31:16]};
        u.tag = s[15:0];
        for (int k = 0; k < mem_pkg::num_ops; k++) begin
            t = rand32();
            u.op_sel[k] = mem_pkg::src_e'(4'(t % 13));
            u.dest_sel[k].kind = mem_pkg::dest_kind_e'(t[9:8]);
            u.dest_sel[k].idx = t[11:10];
        end
        return u;
    endfunction

    // non-rep uop whose operands come from both memory streams
    function automatic mem_pkg::mem_uop_t read_uop(input logic [31:0] a1, input logic [31:0] a2);
        mem_pkg::mem_uop_t u;
        u = random_uop(1'b0, 0);
        u.mem_addr1 = a1;
        u.mem_addr2 = a2;
        u.op_sel[0] = mem_pkg::src_mem1;
        u.op_sel[1] = mem_pkg::src_mem2;
        u.op_sel[2] = mem_pkg::src_mem2;
        u.op_sel[3] = mem_pkg::src_mem1;
        return u;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_result(input mem_pkg::mem_result_t got,
                                  input mem_pkg::mem_result_t exp);
        check_value("result.last", got.last, exp.last);
        check_value("result.opsize", got.opsize, exp.opsize);
        check_value("result.eip", got.eip, exp.eip);
        check_value("result.tag", got.tag, exp.tag);
        for (int k = 0; k < mem_pkg::num_ops; k++) begin
            check_value($sformatf("result.op_val[%0d]", k), got.op_val[k], exp.op_val[k]);
            check_value($sformatf("result.dest[%0d]", k), got.dest[k], exp.dest[k]);
        end
    endtask

    // model of the output register
    always @(posedge clk) begin
        if (!arst_n || clr) begin
            exp_cur = '0;
            exp_full = 1'b1;
        end else if (!fwd_stall) begin
            if (exp_issue) begin
                if (exp_q.size() == 0) begin
                    abort_run("an iteration issued with no expected result queued");
                end
                exp_cur = exp_q.pop_front();
                exp_full = 1'b1;
            end else begin
                // only valid is defined in a bubble
                exp_cur = '0;
                exp_full = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        check_value("result.valid", result.valid, exp_cur.valid);
        if (exp_full) begin
            compare_result(result, exp_cur);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
        uop.valid = 1'b0;
        wb.valid = 1'b0;
        clr = 1'b0;
        fwd_stall = 1'b0;
    endtask

    // checks stall mid-cycle, queues an issued iteration and mirrors writeback
    task automatic sample_mid(input int iter, input int n);
        @(negedge clk);
        check_value("stall", stall, fwd_stall || (iter < n - 1));
        exp_issue = 1'b0;
        if (uop.valid && iter < n && !fwd_stall && !clr) begin
            exp_q.push_back(expect_result(uop, regs, iter, n));
            exp_issue = 1'b1;
        end
        if (wb.valid) begin
            shadow[word_index(wb.addr)] = wb.data;
        end
    endtask

    task automatic idle_cycle();
        next_cycle();
        sample_mid(0, 0);
    endtask

    // holds the uop until every iteration has left the stepper
    task automatic run_uop(input mem_pkg::mem_uop_t u, input mem_pkg::reg_read_t r,
                           input int stall_pct);
        int n;
        int iter;
        int waited;
        n = u.is_rep ? int'(u.rep_count) : 1;
        iter = 0;
        waited = 0;
        do begin
            next_cycle();
            uop = u;
            regs = r;
            if (int'(rand32() % 100) < stall_pct) fwd_stall = 1'b1;
            sample_mid(iter, n);
            if (!fwd_stall && iter < n) iter++;
            waited++;
            if (waited > 100) abort_run("timeout: the iterations of a uop never all issued");
        end while (iter < n);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            idle_cycle();
            waited++;
            if (waited > 20) abort_run("timeout: expected results never reached the output");
        end
        idle_cycle();
    endtask

    initial begin
        mem_pkg::mem_uop_t u;
        logic [31:0]       wa;
        lcg_state = 32'd4;
        arst_n = 1'b0;
        clr = 1'b0;
        fwd_stall = 1'b0;
        uop = '0;
        regs = '0;
        wb = '0;
        exp_cur = '0;
        exp_full = 1'b1;
        exp_issue = 1'b0;

        repeat (3) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("result.valid", result.valid, 1'b0);
        check_value("stall", stall, 1'b0);

        // preload every word with a pattern tied to the full byte address
        for (int w = 0; w < dmem_words; w++) begin
            next_cycle();
            wb.valid = 1'b1;
            wb.addr = 32'(w) << 3;
            wb.data = {~wb.addr, wb.addr ^ 32'h5a5a_c3c3};
            sample_mid(0, 0);
        end

        // flush in the middle of a rep walk
        u = random_uop(1'b1, 3);
        next_cycle();
        uop = u;
        regs = random_regs();
        sample_mid(0, 3);
        next_cycle();
        clr = 1'b1;
        sample_mid(0, 0);
        idle_cycle();
        check_value("result.valid", result.valid, 1'b0);
        check_value("stall", stall, 1'b0);
        // a fresh rep restarts at its first iteration
        run_uop(random_uop(1'b1, 4), random_regs(), 0);

        // operand and destination routing
        for (int k = 0; k < 40; k++) begin
            run_uop(random_uop(1'b0, 0), random_regs(), 0);
        end
        drain();

        // writeback then read, and read during write
        for (int k = 0; k < 8; k++) begin
            wa = rand32();
            next_cycle();
            wb.valid = 1'b1;
            wb.addr = wa;
            wb.data = {rand32(), rand32()};
            sample_mid(0, 0);
            run_uop(read_uop(wa, rand32()), random_regs(), 0);
            u = read_uop(wa, wa + 32'd8);
            next_cycle();
            wb.valid = 1'b1;
            wb.addr = wa;
            wb.data = {rand32(), rand32()};
            uop = u;
            regs = random_regs();
            sample_mid(0, 1);
            run_uop(read_uop(wa, wa), random_regs(), 0);
        end
        drain();

        // rep walks with counts 0 to 5 in both directions
        for (int c = 0; c <= 5; c++) begin
            for (int d = 0; d < 2; d++) begin
                u = random_uop(1'b1, c);
                u.df = d[0];
                run_uop(u, random_regs(), 0);
            end
        end
        drain();

        // rep walking under downstream stall
        for (int k = 0; k < 12; k++) begin
            u = random_uop(1'b1, 1 + int'(rand32() % 5));
            run_uop(u, random_regs(), 35);
        end
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule
